//--- rtl/evn_pkg.sv
/*
  event package
  strobe struct shared by the event inputs, outputs and status word,
  plus the sizes of the event source selection
*/

`default_nettype none

package evn_pkg;

  ////////////////////
  // event sources
  ////////////////////

  // number of event source inputs
  localparam int unsigned EN = 4;

  // select value width
  localparam int unsigned EL = $clog2(EN);

  // source picked out of reset
  localparam logic [EL-1:0] ER = EL'(0);

  ////////////////////
  // event strobes
  ////////////////////

  // one bit per event kind, rst is the msb
  typedef struct packed {
    // clear run state and counter
    logic rst;
    // start counting
    logic str;
    // stop counting
    logic stp;
    // software trigger
    logic swt;
  } evn_t;

endpackage

`default_nettype wire

//--- rtl/ctrg_pkg.sv
/*
  trigger counter package
  register bus request and response, register map, trigger and
  counter sizes
*/

`default_nettype none

package ctrg_pkg;

  ////////////////////
  // sizes
  ////////////////////

  // hardware trigger inputs
  localparam int unsigned TN = 4;
  // counter width
  localparam int unsigned CW = 32;
  // decoded address bits
  localparam int unsigned BAW = 5;
  // bus data width
  localparam int unsigned DW = 32;

  ////////////////////
  // register map
  ////////////////////

  // control write, status read
  localparam logic [BAW-1:0] ADR_CTL = 5'h00;
  // event select
  localparam logic [BAW-1:0] ADR_EVN = 5'h04;
  // trigger mask
  localparam logic [BAW-1:0] ADR_TRG = 5'h08;
  // trigger count, read only
  localparam logic [BAW-1:0] ADR_CNT = 5'h10;

  ////////////////////
  // bus
  ////////////////////

  // single cycle request, wen and ren exclusive
  typedef struct packed {
    logic           wen;
    logic           ren;
    logic [BAW-1:0] addr;
    logic [DW-1:0]  wdata;
  } bus_req_t;

  // ack one cycle after the request, rdata valid with ack
  typedef struct packed {
    logic          ack;
    logic          err;
    logic [DW-1:0] rdata;
  } bus_rsp_t;

endpackage

`default_nettype wire

//--- rtl/ctrg_regs.sv
/*
  trigger counter control
  register bus decode, event select and trigger mask registers,
  software event pulses, status and count readback
*/

`timescale 1ns/1ps
`default_nettype none

module ctrg_regs (
  input  logic                            bus,
  input  logic                            arst_n,
  // register bus
  input  ctrg_pkg::bus_req_t              bus_req,
  output ctrg_pkg::bus_rsp_t              bus_rsp,
  // software events
  output evn_pkg::evn_t                   evo,
  // configuration
  output logic [evn_pkg::EL-1:0]          cfg_evn,
  output logic [ctrg_pkg::TN-1:0]         cfg_trg,
  // status from the counter
  input  logic                            run,
  input  logic [ctrg_pkg::CW-1:0]         cnt
);

  ////////////////////
  // local signals
  ////////////////////

  // address hits
  logic wr_ctl;
  logic wr_evn;
  logic wr_trg;

  // registered response
  logic                    ack_q;
  logic [ctrg_pkg::DW-1:0] rdata_q;

  // read mux output
  logic [ctrg_pkg::DW-1:0] rd_mux;

  // run status word
  evn_pkg::evn_t sts;

  ////////////////////
  // decode
  ////////////////////

  assign wr_ctl = bus_req.wen & (bus_req.addr == ctrg_pkg::ADR_CTL);
  assign wr_evn = bus_req.wen & (bus_req.addr == ctrg_pkg::ADR_EVN);
  assign wr_trg = bus_req.wen & (bus_req.addr == ctrg_pkg::ADR_TRG);

  // one ack per request, no back-pressure
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus_req.wen | bus_req.ren;
    end
  end

  ////////////////////
  // configuration
  ////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      cfg_evn <= evn_pkg::ER;
      cfg_trg <= '0;
    end else begin
      // truncated to the register width
      if (wr_evn) begin
        cfg_evn <= bus_req.wdata[evn_pkg::EL-1:0];
      end
      if (wr_trg) begin
        cfg_trg <= bus_req.wdata[ctrg_pkg::TN-1:0];
      end
    end
  end

  // software event pulse, one cycle after the control write
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      evo <= '0;
    end else if (wr_ctl) begin
      evo <= evn_pkg::evn_t'(bus_req.wdata[$bits(evn_pkg::evn_t)-1:0]);
    end else begin
      evo <= '0;
    end
  end

  ////////////////////
  // readback
  ////////////////////

  // str and stp mirror the run flag
  assign sts = '{rst: 1'b0, str: run, stp: ~run, swt: 1'b0};

  // zero extended, unmapped reads as zero
  always_comb begin
    rd_mux = '0;
    case (bus_req.addr)
      ctrg_pkg::ADR_CTL: rd_mux[$bits(evn_pkg::evn_t)-1:0] = sts;
      ctrg_pkg::ADR_EVN: rd_mux[evn_pkg::EL-1:0] = cfg_evn;
      ctrg_pkg::ADR_TRG: rd_mux[ctrg_pkg::TN-1:0] = cfg_trg;
      ctrg_pkg::ADR_CNT: rd_mux[ctrg_pkg::CW-1:0] = cnt;
      default: rd_mux = '0;
    endcase
  end

  // captured on read, held otherwise
  always_ff @(posedge bus) begin
    if (bus_req.ren) begin
      rdata_q <= rd_mux;
    end
  end

  // error flag tied low
  assign bus_rsp = '{ack: ack_q, err: 1'b0, rdata: rdata_q};

endmodule

`default_nettype wire

//--- rtl/ctrg_evn_sel.sv
/*
  event selector
  registered pick of one event source out of the inputs
*/

`timescale 1ns/1ps
`default_nettype none

module ctrg_evn_sel (
  input  logic                               bus,
  input  logic                               arst_n,
  // event sources
  input  evn_pkg::evn_t [evn_pkg::EN-1:0]    evi,
  // source index
  input  logic          [evn_pkg::EL-1:0]    cfg_evn,
  // selected events
  output evn_pkg::evn_t                      evn
);

  // combinational pick
  evn_pkg::evn_t sel;

  // index without a source leaves sel at zero
  always_comb begin
    sel = '0;
    for (int i = 0; i < int'(evn_pkg::EN); i++) begin
      if (int'(cfg_evn) == i) begin
        sel = evi[i];
      end
    end
  end

  // one cycle from evi to evn
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      evn <= '0;
    end else begin
      evn <= sel;
    end
  end

endmodule

`default_nettype wire

//--- rtl/ctrg_trg_cnt.sv
/*
  trigger counter
  masked hardware triggers or'ed with the software trigger,
  run state, counter while running, one pulse per counted trigger
*/

`timescale 1ns/1ps
`default_nettype none

module ctrg_trg_cnt (
  input  logic                        bus,
  input  logic                        arst_n,
  // selected events
  input  evn_pkg::evn_t               evn,
  // hardware triggers and mask
  input  logic [ctrg_pkg::TN-1:0]     trg,
  input  logic [ctrg_pkg::TN-1:0]     cfg_trg,
  // status
  output logic                        run,
  output logic [ctrg_pkg::CW-1:0]     cnt,
  // trigger pulse
  output logic                        tro
);

  ////////////////////
  // trigger combine
  ////////////////////

  // masked triggers, one cycle late
  logic [ctrg_pkg::TN-1:0] trg_q;

  // any trigger this cycle
  logic trg_any;

  // counted this cycle
  logic inc;

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      trg_q <= '0;
    end else begin
      trg_q <= trg & cfg_trg;
    end
  end

  assign trg_any = (|trg_q) | evn.swt;

  // uses run from before the edge, rst blocks the count
  assign inc = run & trg_any & ~evn.rst;

  ////////////////////
  // run and count
  ////////////////////

  // rst over str over stp
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      run <= 1'b0;
    end else if (evn.rst) begin
      run <= 1'b0;
    end else if (evn.str) begin
      run <= 1'b1;
    end else if (evn.stp) begin
      run <= 1'b0;
    end
  end

  // wraps at the top of the range
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
    end else if (evn.rst) begin
      cnt <= '0;
    end else if (inc) begin
      cnt <= cnt + {{(ctrg_pkg::CW-1){1'b0}}, 1'b1};
    end
  end

  // high while the new count is visible
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      tro <= 1'b0;
    end else begin
      tro <= inc;
    end
  end

endmodule

`default_nettype wire

//--- rtl/ctrg_top.sv
/*
  trigger counter top
  control registers, event selector and trigger counter
*/

`timescale 1ns/1ps
`default_nettype none

module ctrg_top (
  input  logic                               bus,
  input  logic                               arst_n,
  // register bus
  input  ctrg_pkg::bus_req_t                 bus_req,
  output ctrg_pkg::bus_rsp_t                 bus_rsp,
  // events
  input  evn_pkg::evn_t [evn_pkg::EN-1:0]    evi,
  output evn_pkg::evn_t                      evo,
  // triggers
  input  logic          [ctrg_pkg::TN-1:0]   trg,
  output logic                               tro
);

  // configuration to the datapath
  logic [evn_pkg::EL-1:0]  cfg_evn;
  logic [ctrg_pkg::TN-1:0] cfg_trg;

  // selected events
  evn_pkg::evn_t evn;

  // status back to control
  logic                    run;
  logic [ctrg_pkg::CW-1:0] cnt;

  ////////////////////
  // control
  ////////////////////

  ctrg_regs u_regs (
    .bus     (bus),
    .arst_n  (arst_n),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .evo     (evo),
    .cfg_evn (cfg_evn),
    .cfg_trg (cfg_trg),
    .run     (run),
    .cnt     (cnt)
  );

  ////////////////////
  // datapath
  ////////////////////

  ctrg_evn_sel u_evn_sel (
    .bus     (bus),
    .arst_n  (arst_n),
    .evi     (evi),
    .cfg_evn (cfg_evn),
    .evn     (evn)
  );

  ctrg_trg_cnt u_trg_cnt (
    .bus     (bus),
    .arst_n  (arst_n),
    .evn     (evn),
    .trg     (trg),
    .cfg_trg (cfg_trg),
    .run     (run),
    .cnt     (cnt),
    .tro     (tro)
  );

endmodule

`default_nettype wire

//--- tb/ctrg_chk.sv
/*
  trigger counter assertions
  bus acknowledge, error flag, software event and trigger pulse rules
*/

`timescale 1ns/1ps
`default_nettype none

module ctrg_chk (
  input  logic                    bus,
  input  logic                    arst_n,
  input  ctrg_pkg::bus_req_t      bus_req,
  input  ctrg_pkg::bus_rsp_t      bus_rsp,
  input  evn_pkg::evn_t           evo,
  input  logic [ctrg_pkg::CW-1:0] cnt,
  input  logic                    tro
);

  // failed assertions so far
  int fails = 0;

  // any request this cycle
  logic req;
  // control register write
  logic ctl_wr;

  assign req    = bus_req.wen | bus_req.ren;
  assign ctl_wr = bus_req.wen & (bus_req.addr == ctrg_pkg::ADR_CTL);

  ////////////////////
  // bus
  ////////////////////

  ack_after_req: assert property (@(posedge bus) disable iff (!arst_n)
    req |=> bus_rsp.ack)
    else begin
      fails++;
      $error("request without ack one cycle later");
    end

  no_stray_ack: assert property (@(posedge bus) disable iff (!arst_n)
    !req |=> !bus_rsp.ack)
    else begin
      fails++;
      $error("ack without a request one cycle before");
    end

  err_low: assert property (@(posedge bus) disable iff (!arst_n)
    !bus_rsp.err)
    else begin
      fails++;
      $error("bus error flag high");
    end

  ////////////////////
  // pulses
  ////////////////////

  // evo only right after a control write
  evo_after_ctl: assert property (@(posedge bus) disable iff (!arst_n)
    !ctl_wr |=> (evo == '0))
    else begin
      fails++;
      $error("evo set without a control write");
    end

  // back to back tro means two increments
  tro_counts: assert property (@(posedge bus) disable iff (!arst_n)
    (tro && $past(tro)) |-> (cnt != $past(cnt)))
    else begin
      fails++;
      $error("tro high twice with the count unchanged");
    end

endmodule

`default_nettype wire

//--- tb/ctrg_scoreboard.sv
/*
  trigger counter scoreboard
  reference model of registers, event select, trigger register, run and
  count, compared with the DUT outputs every cycle
*/

`timescale 1ns/1ps
`default_nettype none

module ctrg_scoreboard (
  input  logic                            bus,
  input  logic                            arst_n,
  input  ctrg_pkg::bus_req_t              bus_req,
  input  ctrg_pkg::bus_rsp_t              bus_rsp,
  input  evn_pkg::evn_t [evn_pkg::EN-1:0] evi,
  input  evn_pkg::evn_t                   evo,
  input  logic [ctrg_pkg::TN-1:0]         trg,
  input  logic                            tro,
  output int                              errors
);

  int err_cnt = 0;

  // inputs captured mid cycle, used on the next edge
  ctrg_pkg::bus_req_t              s_req = '0;
  evn_pkg::evn_t [evn_pkg::EN-1:0] s_evi = '0;
  logic [ctrg_pkg::TN-1:0]         s_trg = '0;

  // model state
  logic                    m_ack;
  logic [ctrg_pkg::DW-1:0] m_rdata;
  evn_pkg::evn_t           m_evo;
  logic [evn_pkg::EL-1:0]  m_cfg_evn;
  logic [ctrg_pkg::TN-1:0] m_cfg_trg;
  evn_pkg::evn_t           m_evn;
  logic [ctrg_pkg::TN-1:0] m_trg_q;
  logic                    m_run;
  logic [ctrg_pkg::CW-1:0] m_cnt;
  logic                    m_tro;

  // edge temporaries
  logic                    hit;
  evn_pkg::evn_t           sts;
  logic [ctrg_pkg::DW-1:0] rd;

  assign errors = err_cnt;

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERR %s exp=%h act=%h at %0t", name, exp, act, $time);
    end
  endtask

  ////////////////////
  // model
  ////////////////////

  always @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      m_ack     = 1'b0;
      m_evo     = '0;
      m_cfg_evn = evn_pkg::ER;
      m_cfg_trg = '0;
      m_evn     = '0;
      m_trg_q   = '0;
      m_run     = 1'b0;
      m_cnt     = '0;
      m_tro     = 1'b0;
    end else begin
      // readback sees state from before the edge
      sts = '{rst: 1'b0, str: m_run, stp: !m_run, swt: 1'b0};
      rd  = '0;
      case (s_req.addr)
        ctrg_pkg::ADR_CTL: rd[3:0] = sts;
        ctrg_pkg::ADR_EVN: rd[evn_pkg::EL-1:0] = m_cfg_evn;
        ctrg_pkg::ADR_TRG: rd[ctrg_pkg::TN-1:0] = m_cfg_trg;
        ctrg_pkg::ADR_CNT: rd = m_cnt;
        default: rd = '0;
      endcase
      if (s_req.ren) begin
        m_rdata = rd;
      end
      // counter, old events and trigger register
      hit   = (|m_trg_q) | m_evn.swt;
      m_tro = 1'b0;
      if (m_evn.rst) begin
        m_run = 1'b0;
        m_cnt = '0;
      end else begin
        m_tro = m_run & hit;
        if (m_evn.str) begin
          m_run = 1'b1;
        end else if (m_evn.stp) begin
          m_run = 1'b0;
        end
        if (m_tro) begin
          m_cnt = m_cnt + 32'd1;
        end
      end
      // datapath registers with the old configuration
      m_trg_q = s_trg & m_cfg_trg;
      m_evn   = s_evi[m_cfg_evn];
      // bus side
      m_ack = s_req.wen | s_req.ren;
      m_evo = '0;
      if (s_req.wen && s_req.addr == ctrg_pkg::ADR_CTL) begin
        m_evo = evn_pkg::evn_t'(s_req.wdata[3:0]);
      end
      if (s_req.wen && s_req.addr == ctrg_pkg::ADR_EVN) begin
        m_cfg_evn = s_req.wdata[evn_pkg::EL-1:0];
      end
      if (s_req.wen && s_req.addr == ctrg_pkg::ADR_TRG) begin
        m_cfg_trg = s_req.wdata[ctrg_pkg::TN-1:0];
      end
    end
  end

  ////////////////////
  // compare
  ////////////////////

  // outputs settled, inputs stable until after the next edge
  always @(negedge bus) begin
    if (arst_n) begin
      check("ack", 32'(m_ack), 32'(bus_rsp.ack));
      check("err", 32'(1'b0), 32'(bus_rsp.err));
      check("evo", 32'(m_evo), 32'(evo));
      check("tro", 32'(m_tro), 32'(tro));
      if (m_ack) begin
        check("rdata", m_rdata, bus_rsp.rdata);
      end
    end
    s_req = bus_req;
    s_evi = evi;
    s_trg = trg;
  end

endmodule

`default_nettype wire

//--- tb/ctrg_tb.sv
/*
  trigger counter testbench
  seeded random bus, event and trigger stimulus over five tests,
  scoreboard and bound assertions do the checking
*/

`timescale 1ns/1ps
`default_nettype none

module ctrg_tb;

  ////////////////////
  // run length
  ////////////////////

  localparam int unsigned SEED = 32'h4fe644e7;
  // cycles per test, reset first
  localparam int T_RST   = 16;
  localparam int T_RDRST = 8;
  localparam int T_REGS  = 82;
  localparam int T_SWEV  = 42;
  localparam int T_HWTRG = 67;
  localparam int T_MIX   = 213;
  // 20% margin
  localparam int LIMIT = (T_RST + T_RDRST + T_REGS + T_SWEV + T_HWTRG + T_MIX) * 6 / 5;
  // event input fed from evo
  localparam int FB_SLOT = 3;

  logic                            bus = 1'b0;
  logic                            arst_n = 1'b0;
  ctrg_pkg::bus_req_t              bus_req = '0;
  ctrg_pkg::bus_rsp_t              bus_rsp;
  evn_pkg::evn_t [evn_pkg::EN-1:0] evi;
  evn_pkg::evn_t [evn_pkg::EN-1:0] evi_rnd = '0;
  evn_pkg::evn_t                   evo;
  logic [ctrg_pkg::TN-1:0]         trg = '0;
  logic                            tro;

  // stimulus modes
  logic trg_on = 1'b0;
  logic evi_on = 1'b0;
  logic fb_on  = 1'b0;

  int cycles   = 0;
  int sb_errors;
  int n_tests  = 0;
  int n_failed = 0;
  int err_base = 0;
  int total;

  initial begin
    forever #2 bus = ~bus;
  end

  // software event path
  always_comb begin
    evi = evi_rnd;
    if (fb_on) begin
      evi[FB_SLOT] = evn_pkg::evn_t'(evi_rnd[FB_SLOT] | evo);
    end
  end

  ctrg_top DUT (
    .bus     (bus),
    .arst_n  (arst_n),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .evi     (evi),
    .evo     (evo),
    .trg     (trg),
    .tro     (tro)
  );

  ctrg_scoreboard u_sb (
    .bus     (bus),
    .arst_n  (arst_n),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .evi     (evi),
    .evo     (evo),
    .trg     (trg),
    .tro     (tro),
    .errors  (sb_errors)
  );

  bind ctrg_top ctrg_chk u_chk (
    .bus     (bus),
    .arst_n  (arst_n),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .evo     (evo),
    .cnt     (cnt),
    .tro     (tro)
  );

  always @(posedge bus) begin
    cycles <= cycles + 1;
    if (cycles > LIMIT) begin
      $display("timeout, the run went past %0d cycles", LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  ////////////////////
  // stimulus tasks
  ////////////////////

  // one clock, new request plus random triggers and events
  task automatic bus_cycle(input ctrg_pkg::bus_req_t req);
    logic [31:0] r;
    @(posedge bus);
    #1;
    bus_req = req;
    r = $urandom;
    trg = trg_on ? r[ctrg_pkg::TN-1:0] : '0;
    for (int i = 0; i < evn_pkg::EN; i++) begin
      // sparse strobes, each bit about one in eight
      r = $urandom & $urandom & $urandom;
      evi_rnd[i] = evi_on ? evn_pkg::evn_t'(r[3:0]) : '0;
    end
  endtask

  task automatic write_reg(input logic [ctrg_pkg::BAW-1:0] a, input logic [31:0] d);
    bus_cycle('{wen: 1'b1, ren: 1'b0, addr: a, wdata: d});
  endtask

  task automatic read_reg(input logic [ctrg_pkg::BAW-1:0] a);
    bus_cycle('{wen: 1'b0, ren: 1'b1, addr: a, wdata: '0});
  endtask

  task automatic idle(input int n);
    repeat (n) bus_cycle('0);
  endtask

  // control write, then let it reach the counter
  task automatic sw_event(input logic [31:0] ev);
    write_reg(ctrg_pkg::ADR_CTL, ev);
    idle(3);
  endtask

  task automatic end_test(input string name);
    int now;
    int delta;
    now = sb_errors + DUT.u_chk.fails;
    delta = now - err_base;
    err_base = now;
    n_tests++;
    if (delta != 0) begin
      n_failed++;
    end
    $display("test %0d %s: %0d errors", n_tests, name, delta);
  endtask

  ////////////////////
  // tests
  ////////////////////

  initial begin
    void'($urandom(SEED));
    repeat (T_RST) @(posedge bus);
    #1;
    arst_n = 1'b1;

    // reset values, then two unmapped offsets
    read_reg(ctrg_pkg::ADR_CTL);
    read_reg(ctrg_pkg::ADR_EVN);
    read_reg(ctrg_pkg::ADR_TRG);
    read_reg(ctrg_pkg::ADR_CNT);
    read_reg(5'h0C);
    read_reg(5'h1C);
    idle(2);
    end_test("reset_values");

    // back to back writes and readback
    repeat (20) begin
      write_reg(ctrg_pkg::ADR_EVN, $urandom);
      write_reg(ctrg_pkg::ADR_TRG, $urandom);
      read_reg(ctrg_pkg::ADR_EVN);
      read_reg(ctrg_pkg::ADR_TRG);
    end
    idle(2);
    end_test("config_readback");

    // bits 3..0 are rst, str, stp, swt
    fb_on = 1'b1;
    write_reg(ctrg_pkg::ADR_EVN, FB_SLOT);
    sw_event(32'h8);
    // swt before run is not counted
    sw_event(32'h1);
    read_reg(ctrg_pkg::ADR_CNT);
    sw_event(32'h4);
    read_reg(ctrg_pkg::ADR_CTL);
    repeat (5) write_reg(ctrg_pkg::ADR_CTL, 32'h1);
    idle(3);
    read_reg(ctrg_pkg::ADR_CNT);
    // rst wins over str
    sw_event(32'hC);
    read_reg(ctrg_pkg::ADR_CTL);
    read_reg(ctrg_pkg::ADR_CNT);
    // running again, then stopped
    sw_event(32'h4);
    read_reg(ctrg_pkg::ADR_CTL);
    sw_event(32'h2);
    read_reg(ctrg_pkg::ADR_CTL);
    idle(2);
    end_test("software_events");

    // masked hardware triggers while running
    write_reg(ctrg_pkg::ADR_TRG, $urandom | 32'h1);
    sw_event(32'h4);
    trg_on = 1'b1;
    idle(50);
    trg_on = 1'b0;
    idle(3);
    read_reg(ctrg_pkg::ADR_CNT);
    read_reg(ctrg_pkg::ADR_CTL);
    sw_event(32'h2);
    read_reg(ctrg_pkg::ADR_CNT);
    idle(2);
    end_test("hardware_triggers");

    // random events on every input, one source selected
    fb_on  = 1'b0;
    evi_on = 1'b1;
    trg_on = 1'b1;
    write_reg(ctrg_pkg::ADR_TRG, $urandom);
    repeat (10) begin
      write_reg(ctrg_pkg::ADR_EVN, $urandom);
      idle(18);
      read_reg(ctrg_pkg::ADR_CNT);
      read_reg(ctrg_pkg::ADR_CTL);
    end
    evi_on = 1'b0;
    trg_on = 1'b0;
    idle(2);
    end_test("event_mix");

    total = sb_errors + DUT.u_chk.fails;
    $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, total);
    if (n_failed == 0 && total == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
rtl/evn_pkg.sv
rtl/ctrg_pkg.sv
rtl/ctrg_regs.sv
rtl/ctrg_evn_sel.sv
rtl/ctrg_trg_cnt.sv
rtl/ctrg_top.sv
tb/ctrg_chk.sv
tb/ctrg_scoreboard.sv
tb/ctrg_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = ctrg_tb
FILELIST = files.f
OBJ      = obj_dir
LOG      = sim.log
RUN_ARGS = +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove the build output and the log"
	@echo "  help   list the targets"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "FAILED"; exit 1; fi
	@if ! grep -q "Everything OK" $(LOG); then echo "FAILED, run ended early"; exit 1; fi
	@echo "PASSED"

clean:
	rm -rf $(OBJ) $(LOG)
